/* Bender.yml */
package:
  name: vic_timing

sources:
  - verilog/vicPkg.sv
  - verilog/phaseTimer.sv
  - verilog/rasterCounter.sv
  - verilog/cycleSequencer.sv
  - verilog/registerFile.sv
  - verilog/busInterface.sv
  - verilog/vicTop.sv
  - target: simulation
    files:
      - dv/vicProperties.sv
      - dv/vicTb.sv

/* dv/vicProperties.sv */
`timescale 1ns/1ps

module vicProperties (
  input logic           clk_dot4x,
  input logic           rst,
  input vicPkg::cycle_t vicCycle,
  input logic           ras,
  input logic           cas,
  input logic           aec
);

  // ------------------------------
  // dram strobes
  // ------------------------------
  // cas only drops inside an open ras
  casNeedsRas: assert property (@(posedge clk_dot4x) disable iff (rst) !cas |-> !ras)
    else $error("cas active while ras is inactive");

  rasBeforeCas: assert property (@(posedge clk_dot4x) disable iff (rst) $fell(ras) |-> cas)
    else $error("ras fell after cas was already active");

  // idle slots leave the dram untouched
  idleQuiet: assert property (@(posedge clk_dot4x) disable iff (rst)
    (vicCycle inside {vicPkg::LPI2, vicPkg::LI}) |-> (ras && cas))
    else $error("ras or cas active in an idle slot");

  // bus stays with the vic out of reset
  aecLowAfterReset: assert property (@(posedge clk_dot4x) rst |=> !aec)
    else $error("aec high right after reset");

endmodule

bind busInterface vicProperties props (
  .clk_dot4x (clk_dot4x),
  .rst       (rst),
  .vicCycle  (vicCycle),
  .ras       (ras),
  .cas       (cas),
  .aec       (aec)
);

/* dv/vicTb.sv */
`timescale 1ns/1ps

module vicTb;

  localparam vicPkg::chipModel_t ChipModel = vicPkg::CHIP6569;
  localparam vicPkg::limits_t Limits = vicPkg::chipLimits(ChipModel);
  // one raster cycle is 8 dots, one phi period is 32 clocks
  localparam int LineCycles = (int'(Limits.rasterXMax) + 1) / 8;
  localparam int LineCount = int'(Limits.rasterLineMax) + 1;
  localparam int LineClocks = LineCycles * 32;
  localparam int FrameClocks = LineClocks * LineCount;
  // the slowest path waits about two frames
  localparam int TimeoutClocks = 3 * FrameClocks + 8 * LineClocks;
  // first LP comes right after the idle pairs, refresh 16 periods later
  localparam int FirstSprite = 55 + int'(Limits.idleCycles);
  localparam int FirstRefresh = (FirstSprite + 16) % LineCycles;

  logic clk_dot4x;
  logic rst;
  vicPkg::cpuBus_t cpu;
  logic clkPhi;
  logic clkDot;
  logic ras;
  logic cas;
  logic mux;
  logic aec;
  logic denN;
  logic dir;
  logic irq;
  vicPkg::dramAddr_t ado;
  vicPkg::busData_t dbo;
  vicPkg::cycle_t vicCycle;

  // dot4x edges since reset release
  int unsigned edgeCount;
  integer seed;
  logic [7:0] data;
  vicPkg::busData_t value;
  vicPkg::rasterLine_t cmpLine;
  vicPkg::regAddr_t testRegs [6];

  vicTop #(
    .ChipModel (ChipModel)
  ) uut (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .cpu       (cpu),
    .clkPhi    (clkPhi),
    .clkDot    (clkDot),
    .ras       (ras),
    .cas       (cas),
    .mux       (mux),
    .aec       (aec),
    .denN      (denN),
    .dir       (dir),
    .irq       (irq),
    .ado       (ado),
    .dbo       (dbo),
    .vicCycle  (vicCycle)
  );

  always #20 clk_dot4x = ~clk_dot4x;

  always @(posedge clk_dot4x) begin
    if (rst) begin
      edgeCount <= 0;
    end else begin
      edgeCount <= edgeCount + 1;
    end
  end

  // ------------------------------
  // reference model
  // ------------------------------
  // state after n edges, 16 ticks per phi half
  function automatic logic refPhi(input int unsigned n);
    return n[4];
  endfunction

  function automatic vicPkg::tick_t refTick(input int unsigned n);
    return n[3:0];
  endfunction

  // the dot counter steps on edges 0, 4, 8 ...
  function automatic int refLine(input int unsigned n);
    return ((n + 3) / 4 / (LineCycles * 8)) % LineCount;
  endfunction

  function automatic vicPkg::cycle_t pickHalf(input logic phi, input vicPkg::cycle_t low,
                                              input vicPkg::cycle_t high);
    if (phi) begin
      return high;
    end
    return low;
  endfunction

  // sprite slots, refresh, graphics up to 54, then idle pairs
  function automatic vicPkg::cycle_t expectedCycle(input int unsigned n);
    int cyc;
    int k;
    logic phi;
    cyc = (n / 32) % LineCycles;
    phi = refPhi(n);
    // periods since the first sprite pointer slot
    k = (cyc - FirstSprite + LineCycles) % LineCycles;
    if (k < 16) begin
      if (k % 2 == 0) begin
        return pickHalf(phi, vicPkg::LP, vicPkg::HPI1);
      end
      return pickHalf(phi, vicPkg::LPI2, vicPkg::HPI3);
    end else if (k < 21) begin
      if (k == 20) begin
        return pickHalf(phi, vicPkg::LR, vicPkg::HRX);
      end
      return pickHalf(phi, vicPkg::LR, vicPkg::HRI);
    end else if (cyc <= 54) begin
      if (cyc == 54) begin
        return pickHalf(phi, vicPkg::LG, vicPkg::HI);
      end
      return pickHalf(phi, vicPkg::LG, vicPkg::HGI);
    end
    return pickHalf(phi, vicPkg::LI, vicPkg::HI);
  endfunction

  // low from fallTick to the end of the half, high through idle slots
  // mux also stays high in refresh, a row-only access
  function automatic logic expectedStrobe(input int unsigned n, input vicPkg::tick_t fallTick,
                                          input logic highInRefresh);
    vicPkg::cycle_t cyc;
    cyc = expectedCycle(n);
    if ((cyc == vicPkg::LPI2) || (cyc == vicPkg::LI)) begin
      return 1'b1;
    end
    if (highInRefresh && (cyc == vicPkg::LR)) begin
      return 1'b1;
    end
    return refTick(n) < fallTick;
  endfunction

  // aec is phi one dot4x cycle later, low straight out of reset
  function automatic logic expectedAec(input int unsigned n);
    if (n == 0) begin
      return 1'b0;
    end
    return refPhi(n - 1);
  endfunction

  // data buffer on while the vic owns the bus or the cpu selects the chip
  function automatic logic expectedDenN(input logic cpuOwns, input vicPkg::cpuBus_t bus);
    return cpuOwns && bus.ce;
  endfunction

  // buffer turns toward the cpu only for a register read
  function automatic logic expectedDir(input logic cpuOwns, input vicPkg::cpuBus_t bus);
    return !(cpuOwns && !bus.ce && bus.rw);
  endfunction

  // five refreshes per line, counting down from 0xFF each frame
  function automatic logic [7:0] expectedRefresh(input int unsigned n);
    int line;
    int slot;
    line = (n / LineClocks) % LineCount;
    slot = ((n / 32) % LineCycles - FirstRefresh + LineCycles) % LineCycles;
    return 8'hFF - 8'((5 * line + slot) % 256);
  endfunction

  // unused bits read as 1, bit 7 of control 1 is raster bit 8
  function automatic vicPkg::busData_t expectedReadback(input vicPkg::regAddr_t addr,
                                                        input logic [7:0] written,
                                                        input vicPkg::rasterLine_t line);
    case (addr)
      vicPkg::REG_SCREEN_CONTROL_1: return {4'hF, line[8], written[6:0]};
      vicPkg::REG_MEMORY_SETUP: return {4'hF, written[7:1], 1'b1};
      vicPkg::REG_INTERRUPT_CONTROL: return {4'hF, 7'h7F, written[0]};
      default: return {8'hFF, written[3:0]};
    endcase
  endfunction

  // ------------------------------
  // checks
  // ------------------------------
  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (expected === actual) else begin
      $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
      $display("Regression failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  // mid-cycle sampling, away from the active edge
  always @(negedge clk_dot4x) begin
    if (!rst) begin
      checkValue("phi clock", refPhi(edgeCount), clkPhi);
      checkValue("dot clock", (edgeCount % 4) < 2, clkDot);
      checkValue("cycle sequence", expectedCycle(edgeCount), vicCycle);
      checkValue("ras strobe", expectedStrobe(edgeCount, 4'd5, 1'b0), ras);
      checkValue("cas strobe", expectedStrobe(edgeCount, 4'd7, 1'b0), cas);
      checkValue("mux strobe", expectedStrobe(edgeCount, 4'd5, 1'b1), mux);
      checkValue("aec", expectedAec(edgeCount), aec);
      checkValue("data buffer enable", expectedDenN(expectedAec(edgeCount), cpu), denN);
      checkValue("data buffer direction", expectedDir(expectedAec(edgeCount), cpu), dir);
      if ((expectedCycle(edgeCount) == vicPkg::LR) && (refTick(edgeCount) == 4'd8)) begin
        checkValue("refresh address", expectedRefresh(edgeCount), ado[7:0]);
      end
    end
  end

  always @(posedge clk_dot4x) begin
    assert (edgeCount < TimeoutClocks) else begin
      $display("timeout, the run did not finish within %0d cycles", TimeoutClocks);
      $display("Regression failed");
      $fatal(1, "timeout");
    end
  end

  // ------------------------------
  // cpu bus
  // ------------------------------
  task automatic waitPhase(input logic phi, input vicPkg::tick_t tick);
    do begin
      @(posedge clk_dot4x);
      #1;
    end while ((refPhi(edgeCount) != phi) || (refTick(edgeCount) != tick));
  endtask

  // ce low across regWriteTick of phi high
  task automatic cpuWrite(input vicPkg::regAddr_t addr, input logic [7:0] wdata);
    waitPhase(1'b1, 4'd2);
    cpu.adi = addr;
    cpu.dbi = {4'h0, wdata};
    cpu.rw = 1'b0;
    cpu.ce = 1'b0;
    waitPhase(1'b1, 4'd12);
    cpu.ce = 1'b1;
    cpu.rw = 1'b1;
  endtask

  task automatic cpuRead(input vicPkg::regAddr_t addr, output vicPkg::busData_t rdata);
    waitPhase(1'b1, 4'd2);
    cpu.adi = addr;
    cpu.rw = 1'b1;
    cpu.ce = 1'b0;
    // dbo is registered one cycle behind the address
    waitPhase(1'b1, 4'd4);
    rdata = dbo;
    cpu.ce = 1'b1;
  endtask

  initial begin
    clk_dot4x = 1'b0;
    seed = 32'he7bc_4ae0;
    cpu.adi = 6'h3F;
    cpu.dbi = '0;
    cpu.ce = 1'b1;
    cpu.rw = 1'b1;
    rst = 1'b1;
    testRegs = '{vicPkg::REG_SCREEN_CONTROL_1, vicPkg::REG_MEMORY_SETUP,
                 vicPkg::REG_INTERRUPT_CONTROL, vicPkg::REG_BORDER_COLOR,
                 vicPkg::REG_BACKGROUND_0, vicPkg::REG_BACKGROUND_1};
    repeat (2) @(posedge clk_dot4x);
    #1;
    rst = 1'b0;

    // random readback of every writable register
    for (int i = 0; i < 6; i++) begin
      data = 8'($random(seed));
      cpuWrite(testRegs[i], data);
      cpuRead(testRegs[i], value);
      checkValue($sformatf("readback of register %0h", testRegs[i]),
                 expectedReadback(testRegs[i], data, 9'(refLine(edgeCount - 1))), value);
    end
    cpuRead(vicPkg::REG_RASTER_LINE, value);
    checkValue("raster line readback", {4'hF, 8'(refLine(edgeCount - 1))}, value);

    // raster irq on a random line
    cmpLine = 9'($unsigned($random(seed)) % LineCount);
    cpuWrite(vicPkg::REG_INTERRUPT_CONTROL, 8'h00);
    cpuWrite(vicPkg::REG_SCREEN_CONTROL_1, {cmpLine[8], 7'h1B});
    cpuWrite(vicPkg::REG_RASTER_LINE, cmpLine[7:0]);
    cpuWrite(vicPkg::REG_INTERRUPT_STATUS, 8'h01);
    cpuWrite(vicPkg::REG_INTERRUPT_CONTROL, 8'h01);
    while (irq !== 1'b1) begin
      @(posedge clk_dot4x);
      #1;
    end
    checkValue("raster irq line", cmpLine, refLine(edgeCount));
    cpuRead(vicPkg::REG_RASTER_LINE, value);
    checkValue("raster line at irq", {4'hF, cmpLine[7:0]}, value);
    // write one to clear
    cpuWrite(vicPkg::REG_INTERRUPT_STATUS, 8'h01);
    checkValue("irq after clear", 1'b0, irq);
    cpuRead(vicPkg::REG_INTERRUPT_STATUS, value);
    checkValue("status after clear", 12'hF7E, value);

    // latch still sets with erst off, irq stays low
    cpuWrite(vicPkg::REG_INTERRUPT_CONTROL, 8'h00);
    cmpLine = 9'((refLine(edgeCount) + 3) % LineCount);
    cpuWrite(vicPkg::REG_SCREEN_CONTROL_1, {cmpLine[8], 7'h1B});
    cpuWrite(vicPkg::REG_RASTER_LINE, cmpLine[7:0]);
    cpuWrite(vicPkg::REG_INTERRUPT_STATUS, 8'h01);
    while (refLine(edgeCount) != (int'(cmpLine) + 1) % LineCount) begin
      @(posedge clk_dot4x);
      #1;
      checkValue("irq with erst off", 1'b0, irq);
    end
    cpuRead(vicPkg::REG_INTERRUPT_STATUS, value);
    checkValue("status with erst off", 12'hF7F, value);

    // run into the next frame so the refresh reload is seen
    while (edgeCount < FrameClocks + 16 * LineClocks) begin
      @(posedge clk_dot4x);
    end
    $display("Regression passed");
    $finish;
  end

endmodule

/* verilog.f */
verilog/vicPkg.sv
verilog/phaseTimer.sv
verilog/rasterCounter.sv
verilog/cycleSequencer.sv
verilog/registerFile.sv
verilog/busInterface.sv
verilog/vicTop.sv
dv/vicProperties.sv
dv/vicTb.sv

/* verilog/busInterface.sv */
`timescale 1ns/1ps

module busInterface (
  input  logic                 clk_dot4x,
  input  logic                 rst,
  input  vicPkg::phaseTiming_t timing,
  input  vicPkg::rasterPos_t   pos,
  input  vicPkg::cycle_t       vicCycle,
  input  vicPkg::cpuBus_t      cpu,
  output vicPkg::dramAddr_t    ado,
  output logic                 ras,
  output logic                 cas,
  output logic                 mux,
  output logic                 aec,
  output logic                 denN,
  output logic                 dir
);

  logic rasWindow;
  logic casWindow;
  logic strobesOn;
  logic muxOn;
  logic [7:0] refreshAddr;
  logic lineEndQ;
  logic [13:0] vicAddr;
  logic [7:0] adoLow;

  // ------------------------------
  // dram strobe profiles
  // ------------------------------
  // registered, so ras is low from tick 5 and cas from tick 7
  // both return high on tick 0 of the next half
  assign rasWindow = (timing.tick >= 4'd4) && (timing.tick != 4'd15);
  assign casWindow = (timing.tick >= 4'd6) && (timing.tick != 4'd15);
  // idle slots leave the dram alone
  assign strobesOn = !(vicCycle inside {vicPkg::LPI2, vicPkg::LI});
  // refresh is a ras-only cycle, keep the row on the pins
  assign muxOn = strobesOn && (vicCycle != vicPkg::LR);

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      ras <= 1'b1;
      cas <= 1'b1;
      mux <= 1'b1;
    end else begin
      ras <= !(rasWindow && strobesOn);
      cas <= !(casWindow && strobesOn);
      mux <= !(rasWindow && muxOn);
    end
  end

  // ------------------------------
  // refresh counter
  // ------------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      refreshAddr <= 8'hFF;
      lineEndQ <= 1'b0;
    end else begin
      lineEndQ <= pos.lineEnd;
      // one step per LR phase
      if ((timing.tick == 4'd15) && (vicCycle == vicPkg::LR)) begin
        refreshAddr <= refreshAddr - 8'd1;
      // x just wrapped into line 0
      end else if (lineEndQ && (pos.rasterLine == '0)) begin
        refreshAddr <= 8'hFF;
      end
    end
  end

  // all other slots park on the idle address
  assign vicAddr = (vicCycle == vicPkg::LR) ? {6'h3F, refreshAddr} : 14'h3FFF;

  // row first, column once mux drops
  // the extra register puts the switch between ras and cas
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      adoLow <= 8'hFF;
    end else begin
      adoLow <= mux ? vicAddr[7:0] : {2'b11, vicAddr[13:8]};
    end
  end

  assign ado = {vicAddr[11:8], adoLow};

  // ------------------------------
  // cpu bus buffers
  // ------------------------------
  // no stolen cycles, cpu gets every phi high half
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      aec <= 1'b0;
    end else begin
      aec <= timing.phi;
    end
  end

  // data buffer on while the vic owns the bus or is selected
  assign denN = aec ? cpu.ce : 1'b0;
  // drive the data bus only for a cpu read of a register
  assign dir = aec ? (cpu.ce ? 1'b1 : ~cpu.rw) : 1'b1;

endmodule

/* verilog/cycleSequencer.sv */
`timescale 1ns/1ps

module cycleSequencer #(
  parameter vicPkg::chipModel_t ChipModel = vicPkg::CHIP6569
) (
  input  logic                 clk_dot4x,
  input  logic                 rst,
  input  vicPkg::phaseTiming_t timing,
  input  vicPkg::rasterPos_t   pos,
  output vicPkg::cycle_t       vicCycle
);

  localparam vicPkg::limits_t Limits = vicPkg::chipLimits(ChipModel);
  // last g-access slot of the line
  localparam vicPkg::cycleNum_t LastGraphicsCycle = 7'd54;

  // state picked on tick 14, taken over on the phi edge
  vicPkg::cycle_t nextCycle;
  // stretch counters
  logic [2:0] spriteCnt;
  logic [2:0] refreshCnt;
  logic [2:0] idleCnt;

  // ------------------------------
  // next state
  // ------------------------------
  // LP -> HPI1 -> LPI2 -> HPI3, 8 slots, then LR
  // LR -> HRI -> LR ... 5th LR -> HRX -> LG
  // LG -> HGI -> LG ... LG on cycle 54 -> HI
  // HI -> LI -> HI ... idleCycles pairs, then LP
  // line 0 starts in sprite slot 3 so the stretches line up
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      nextCycle <= vicPkg::LP;
      spriteCnt <= 3'd3;
      refreshCnt <= '0;
      idleCnt <= '0;
    end else if (timing.tick == 4'd14) begin
      if (!timing.phi) begin
        // phi about to go high
        case (vicCycle)
          vicPkg::LP: nextCycle <= vicPkg::HPI1;
          vicPkg::LPI2: nextCycle <= vicPkg::HPI3;
          vicPkg::LR: begin
            if (refreshCnt == 3'd4) begin
              nextCycle <= vicPkg::HRX;
            end else begin
              nextCycle <= vicPkg::HRI;
            end
          end
          vicPkg::LG: begin
            if (pos.cycleNum == LastGraphicsCycle) begin
              nextCycle <= vicPkg::HI;
              idleCnt <= '0;
            end else begin
              nextCycle <= vicPkg::HGI;
            end
          end
          vicPkg::LI: nextCycle <= vicPkg::HI;
          default: ;
        endcase
      end else begin
        // phi about to go low
        case (vicCycle)
          vicPkg::HPI1: nextCycle <= vicPkg::LPI2;
          vicPkg::HPI3: begin
            if (spriteCnt == 3'd7) begin
              nextCycle <= vicPkg::LR;
              spriteCnt <= '0;
              refreshCnt <= '0;
            end else begin
              nextCycle <= vicPkg::LP;
              spriteCnt <= spriteCnt + 3'd1;
            end
          end
          vicPkg::HRI: begin
            nextCycle <= vicPkg::LR;
            refreshCnt <= refreshCnt + 3'd1;
          end
          vicPkg::HRX, vicPkg::HGI: nextCycle <= vicPkg::LG;
          vicPkg::HI: begin
            if (idleCnt == Limits.idleCycles) begin
              nextCycle <= vicPkg::LP;
            end else begin
              nextCycle <= vicPkg::LI;
              idleCnt <= idleCnt + 3'd1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // state only moves together with phi
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      vicCycle <= vicPkg::LP;
    end else if (timing.tick == 4'd15) begin
      vicCycle <= nextCycle;
    end
  end

endmodule

/* verilog/phaseTimer.sv */
`timescale 1ns/1ps

module phaseTimer (
  input  logic                 clk_dot4x,
  input  logic                 rst,
  output vicPkg::phaseTiming_t timing
);

  // position inside the current phi half
  vicPkg::tick_t tick;
  logic phi;

  // 16 ticks per half, so phi period is 32 dot4x cycles
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      tick <= '0;
      phi <= 1'b0;
    end else begin
      tick <= tick + 4'd1;
      // toggle on the wrap 15 -> 0
      if (tick == 4'd15) begin
        phi <= ~phi;
      end
    end
  end

  assign timing.phi = phi;
  assign timing.tick = tick;
  // dot clock rises every 4th tick
  // 4 dots per phi half, 8 per raster cycle
  assign timing.dotRise = (tick[1:0] == 2'b00);

endmodule

/* verilog/rasterCounter.sv */
`timescale 1ns/1ps

module rasterCounter #(
  parameter vicPkg::chipModel_t ChipModel = vicPkg::CHIP6569
) (
  input  logic                 clk_dot4x,
  input  logic                 rst,
  input  vicPkg::phaseTiming_t timing,
  output vicPkg::rasterPos_t   pos
);

  localparam vicPkg::limits_t Limits = vicPkg::chipLimits(ChipModel);

  vicPkg::rasterX_t rasterX;
  vicPkg::rasterLine_t rasterLine;
  // last pixel of the line, one tick wide
  logic xWrap;

  assign xWrap = timing.dotRise && (rasterX == Limits.rasterXMax);

  // ------------------------------
  // pixel and line counters
  // ------------------------------
  // start at (0,0) in phi low, the first dot brings x to 1
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      rasterX <= '0;
      rasterLine <= '0;
    end else if (timing.dotRise) begin
      if (xWrap) begin
        rasterX <= '0;
        // frame wrap
        if (rasterLine == Limits.rasterLineMax) begin
          rasterLine <= '0;
        end else begin
          rasterLine <= rasterLine + 9'd1;
        end
      end else begin
        rasterX <= rasterX + 10'd1;
      end
    end
  end

  assign pos.rasterX = rasterX;
  assign pos.rasterLine = rasterLine;
  // 8 pixels per phi cycle
  assign pos.cycleNum = rasterX[9:3];
  // used for refresh reload and the raster irq latch
  assign pos.lineEnd = xWrap;

endmodule

/* verilog/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
  input  logic                 clk_dot4x,
  input  logic                 rst,
  input  vicPkg::phaseTiming_t timing,
  input  vicPkg::rasterPos_t   pos,
  input  vicPkg::cpuBus_t      cpu,
  input  logic                 aec,
  output vicPkg::busData_t     dbo,
  output logic                 irq
);

  vicPkg::regAddr_t regAddr;
  logic regWrite;
  logic statusClr;
  vicPkg::busData_t readData;

  // screen control 1 fields
  logic [2:0] yScroll;
  logic rowSelect;
  logic displayEnable;
  logic bitmapMode;
  logic extColorMode;
  vicPkg::rasterLine_t rasterCmp;
  // memory setup
  logic [2:0] charBase;
  logic [3:0] videoBase;
  // colours
  vicPkg::color_t borderColor;
  vicPkg::color_t bgColor0;
  vicPkg::color_t bgColor1;
  // raster interrupt
  logic erst;
  logic irst;
  logic rasterIrqDone;
  logic rasterMatch;

  assign regAddr = vicPkg::regAddr_t'(cpu.adi);

  // cpu owns the bus, data is valid mid phi high
  assign regWrite = timing.phi && (timing.tick == vicPkg::regWriteTick) && aec &&
                    !cpu.ce && !cpu.rw;
  // write one to bit 0 of status clears irst
  assign statusClr = regWrite && (regAddr == vicPkg::REG_INTERRUPT_STATUS) && cpu.dbi[0];

  // ------------------------------
  // writes
  // ------------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      yScroll <= 3'd3;
      rowSelect <= 1'b0;
      displayEnable <= 1'b1;
      bitmapMode <= 1'b0;
      extColorMode <= 1'b0;
      rasterCmp <= '0;
      charBase <= '0;
      videoBase <= '0;
      borderColor <= '0;
      bgColor0 <= '0;
      bgColor1 <= '0;
      erst <= 1'b0;
    end else if (regWrite) begin
      case (regAddr)
        vicPkg::REG_SCREEN_CONTROL_1: begin
          yScroll <= cpu.dbi[2:0];
          rowSelect <= cpu.dbi[3];
          displayEnable <= cpu.dbi[4];
          bitmapMode <= cpu.dbi[5];
          extColorMode <= cpu.dbi[6];
          // bit 8 of the compare line
          rasterCmp[8] <= cpu.dbi[7];
        end
        vicPkg::REG_RASTER_LINE: rasterCmp[7:0] <= cpu.dbi[7:0];
        vicPkg::REG_MEMORY_SETUP: begin
          charBase <= cpu.dbi[3:1];
          videoBase <= cpu.dbi[7:4];
        end
        vicPkg::REG_INTERRUPT_CONTROL: erst <= cpu.dbi[0];
        vicPkg::REG_BORDER_COLOR: borderColor <= cpu.dbi[3:0];
        vicPkg::REG_BACKGROUND_0: bgColor0 <= cpu.dbi[3:0];
        vicPkg::REG_BACKGROUND_1: bgColor1 <= cpu.dbi[3:0];
        default: ;
      endcase
    end
  end

  // ------------------------------
  // raster interrupt
  // ------------------------------
  // cycle 0 of the line, cycle 1 on line 0
  assign rasterMatch = (pos.rasterLine == rasterCmp) &&
                       ((pos.rasterLine == '0) ? (pos.cycleNum == 7'd1)
                                                : (pos.cycleNum == 7'd0));

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      irst <= 1'b0;
      rasterIrqDone <= 1'b0;
    end else begin
      // rearm once per line
      if (pos.lineEnd) begin
        rasterIrqDone <= 1'b0;
      end
      if (statusClr) begin
        irst <= 1'b0;
      end
      // latch is set even while erst is off
      if (!rasterIrqDone && rasterMatch) begin
        rasterIrqDone <= 1'b1;
        irst <= 1'b1;
      end
    end
  end

  assign irq = irst & erst;

  // ------------------------------
  // reads
  // ------------------------------
  // unused bits read as 1
  always_comb begin
    readData = '1;
    case (regAddr)
      vicPkg::REG_SCREEN_CONTROL_1: begin
        readData[7:0] = {pos.rasterLine[8], extColorMode, bitmapMode, displayEnable,
                         rowSelect, yScroll};
      end
      vicPkg::REG_RASTER_LINE: readData[7:0] = pos.rasterLine[7:0];
      // scroll and mode bits live in the graphics unit, not present here
      vicPkg::REG_SCREEN_CONTROL_2: readData[7:0] = 8'hFF;
      vicPkg::REG_MEMORY_SETUP: readData[7:0] = {videoBase, charBase, 1'b1};
      vicPkg::REG_INTERRUPT_STATUS: readData[7:0] = {irq, 6'h3F, irst};
      vicPkg::REG_INTERRUPT_CONTROL: readData[7:0] = {7'h7F, erst};
      vicPkg::REG_BORDER_COLOR: readData[7:0] = {4'hF, borderColor};
      vicPkg::REG_BACKGROUND_0: readData[7:0] = {4'hF, bgColor0};
      vicPkg::REG_BACKGROUND_1: readData[7:0] = {4'hF, bgColor1};
      default: ;
    endcase
  end

  // dbo follows the address one dot4x cycle later
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      dbo <= '1;
    end else if (!cpu.ce && cpu.rw) begin
      dbo <= readData;
    end
  end

endmodule

/* verilog/vicPkg.sv */
package vicPkg;

  // ------------------------------
  // chip variants and bus cycles
  // ------------------------------

  // the variant sets line length, frame height and idle stretch
  typedef enum logic [1:0] {
    CHIP6567R8   = 2'd0,
    CHIP6569     = 2'd1,
    CHIP6567R56A = 2'd2
  } chipModel_t;

  // L states own the phi low half, H states the phi high half
  // P sprite pointer, R refresh, G graphics, I idle
  typedef enum logic [3:0] {
    LP,
    HPI1,
    LPI2,
    HPI3,
    LR,
    HRI,
    HRX,
    LG,
    HGI,
    HI,
    LI
  } cycle_t;

  // cpu visible register offsets
  typedef enum logic [5:0] {
    REG_SCREEN_CONTROL_1  = 6'h11,
    REG_RASTER_LINE       = 6'h12,
    REG_SCREEN_CONTROL_2  = 6'h16,
    REG_MEMORY_SETUP      = 6'h18,
    REG_INTERRUPT_STATUS  = 6'h19,
    REG_INTERRUPT_CONTROL = 6'h1a,
    REG_BORDER_COLOR      = 6'h20,
    REG_BACKGROUND_0      = 6'h21,
    REG_BACKGROUND_1      = 6'h22
  } regAddr_t;

  // ------------------------------
  // widths
  // ------------------------------
  typedef logic [9:0]  rasterX_t;
  typedef logic [8:0]  rasterLine_t;
  typedef logic [6:0]  cycleNum_t;
  typedef logic [3:0]  tick_t;
  typedef logic [3:0]  color_t;
  typedef logic [11:0] dramAddr_t;
  typedef logic [11:0] busData_t;

  // ------------------------------
  // bundles
  // ------------------------------
  typedef struct packed {
    logic  phi;
    logic  dotRise;
    tick_t tick;
  } phaseTiming_t;

  typedef struct packed {
    rasterX_t    rasterX;
    rasterLine_t rasterLine;
    cycleNum_t   cycleNum;
    logic        lineEnd;
  } rasterPos_t;

  typedef struct packed {
    logic [5:0] adi;
    busData_t   dbi;
    logic       ce;
    logic       rw;
  } cpuBus_t;

  // cpu write data is sampled on this tick of phi high
  localparam tick_t regWriteTick = 4'd7;

  typedef struct packed {
    rasterX_t    rasterXMax;
    rasterLine_t rasterLineMax;
    logic [2:0]  idleCycles;
  } limits_t;

  function automatic limits_t chipLimits(input chipModel_t chip);
    limits_t lim;
    case (chip)
      // 520 pixels, 263 lines
      CHIP6567R8: begin
        lim.rasterXMax = 10'd519;
        lim.rasterLineMax = 9'd262;
        lim.idleCycles = 3'd4;
      end
      // 512 pixels, 262 lines
      CHIP6567R56A: begin
        lim.rasterXMax = 10'd511;
        lim.rasterLineMax = 9'd261;
        lim.idleCycles = 3'd3;
      end
      // pal, 504 pixels and 312 lines
      default: begin
        lim.rasterXMax = 10'd503;
        lim.rasterLineMax = 9'd311;
        lim.idleCycles = 3'd2;
      end
    endcase
    return lim;
  endfunction

endpackage

/* verilog/vicTop.sv */
`timescale 1ns/1ps

module vicTop #(
  parameter vicPkg::chipModel_t ChipModel = vicPkg::CHIP6569
) (
  input  logic              clk_dot4x,
  input  logic              rst,
  input  vicPkg::cpuBus_t   cpu,
  output logic              clkPhi,
  output logic              clkDot,
  output logic              ras,
  output logic              cas,
  output logic              mux,
  output logic              aec,
  output logic              denN,
  output logic              dir,
  output logic              irq,
  output vicPkg::dramAddr_t ado,
  output vicPkg::busData_t  dbo,
  output vicPkg::cycle_t    vicCycle
);

  vicPkg::phaseTiming_t timing;
  vicPkg::rasterPos_t pos;

  // ------------------------------
  // timing and position
  // ------------------------------
  phaseTimer timer (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .timing    (timing)
  );

  rasterCounter #(
    .ChipModel (ChipModel)
  ) raster (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .timing    (timing),
    .pos       (pos)
  );

  cycleSequencer #(
    .ChipModel (ChipModel)
  ) sequencer (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .timing    (timing),
    .pos       (pos),
    .vicCycle  (vicCycle)
  );

  // ------------------------------
  // cpu and dram side
  // ------------------------------
  registerFile regs (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .timing    (timing),
    .pos       (pos),
    .cpu       (cpu),
    .aec       (aec),
    .dbo       (dbo),
    .irq       (irq)
  );

  busInterface bus (
    .clk_dot4x (clk_dot4x),
    .rst       (rst),
    .timing    (timing),
    .pos       (pos),
    .vicCycle  (vicCycle),
    .cpu       (cpu),
    .ado       (ado),
    .ras       (ras),
    .cas       (cas),
    .mux       (mux),
    .aec       (aec),
    .denN      (denN),
    .dir       (dir)
  );

  assign clkPhi = timing.phi;
  // dot clock high on ticks 0 and 1 of every 4
  assign clkDot = ~timing.tick[1];

endmodule
